// ==== files.f ====
+incdir+common
common/bus_pkg.sv
common/periph_pkg.sv
logic/simplebus_interconnect.sv
logic/scratch_ram.sv
logic/bus_timer.sv
logic/gpio_port.sv
logic/bus_subsystem_top.sv
dv/tb_bus_subsystem.sv

// ==== Bender.yml ====
package:
  name: bus_subsystem

sources:
  - include_dirs:
      - common
    files:
      - common/bus_pkg.sv
      - common/periph_pkg.sv
      - logic/simplebus_interconnect.sv
      - logic/scratch_ram.sv
      - logic/bus_timer.sv
      - logic/gpio_port.sv
      - logic/bus_subsystem_top.sv
      - target: simulation
        files:
          - dv/tb_bus_subsystem.sv

// ==== dv/tb_bus_subsystem.sv ====
`timescale 1ns/1ps
`include "subsys_config.svh"

module tb_bus_subsystem;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int CLK_PERIOD = 8;
    // Cycle budget of the reset, RAM, GPIO, timer, expansion and decode tests
    localparam int BUDGET_CYCLES = 20 + 130 + 30 + 100 + 30 + 40;

    logic                   clock;
    logic                   rst_n;
    sb_addr_t               sb_address;
    sb_data_t               sb_write_data;
    logic                   sb_write_strobe;
    logic                   sb_read_strobe;
    sb_data_t               sb_read_data;
    logic                   sb_ready;
    sb_addr_t               ext_address;
    sb_data_t               ext_write_data;
    logic                   ext_write_strobe;
    logic                   ext_read_strobe;
    sb_data_t               ext_read_data;
    logic                   ext_ready;
    logic [`GPIO_WIDTH-1:0] gpio_in;
    logic [`GPIO_WIDTH-1:0] gpio_out;
    logic                   timer_irq;

    logic [31:0] lfsr_state;
    sb_addr_t    ext_last_address;
    sb_addr_t    ext_last_read;
    sb_data_t    ext_last_data;
    int          ext_write_count;

    bus_subsystem_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_data(input string name, input sb_data_t got, input sb_data_t expected);
        if (got !== expected) begin
            fail_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            fail_run($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, expected));
        end
    endtask

    // Right-shifting Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic sb_data_t random_word(input int bits);
        sb_data_t value;
        value = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Value the external slave returns for a read
    function automatic sb_data_t ext_answer(input sb_addr_t addr);
        return {addr[15:0], ~addr[15:0]} ^ 32'h5A5A_0000;
    endfunction

    // Odd stride keeps the 16 slots on distinct words
    function automatic sb_addr_t ram_addr(input int slot);
        return `RAM_LOW + sb_addr_t'(((slot * 37 + 5) % `RAM_WORDS) * 4);
    endfunction

    // External slave model answering one cycle after the strobe
    always @(posedge clock) begin
        ext_read_data <= '0;
        if (ext_read_strobe) begin
            ext_read_data <= ext_answer(ext_address);
            ext_last_read <= ext_address;
        end
        if (ext_write_strobe) begin
            ext_last_address <= ext_address;
            ext_last_data    <= ext_write_data;
            ext_write_count  <= ext_write_count + 1;
        end
    end

    task automatic bus_write(input sb_addr_t addr, input sb_data_t data);
        @(posedge clock);
        sb_address      <= addr;
        sb_write_data   <= data;
        sb_write_strobe <= 1'b1;
        @(posedge clock);
        sb_write_strobe <= 1'b0;
    endtask

    // Answer sits on sb_read_data only in the cycle after the third edge
    task automatic bus_read(input sb_addr_t addr, output sb_data_t data);
        @(posedge clock);
        sb_address     <= addr;
        sb_read_strobe <= 1'b1;
        @(posedge clock);
        sb_read_strobe <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        check_data("sb_read_data before answer", sb_read_data, '0);
        @(posedge clock);
        @(negedge clock);
        data = sb_read_data;
        @(posedge clock);
        @(negedge clock);
        check_data("sb_read_data after answer", sb_read_data, '0);
    endtask

    task automatic read_expect(input sb_addr_t addr, input sb_data_t expected, input string name);
        sb_data_t got;
        bus_read(addr, got);
        check_data(name, got, expected);
    endtask

    task automatic wait_irq(input logic level, input int max_cycles);
        int n;
        @(negedge clock);
        for (n = 0; n < max_cycles && timer_irq !== level; n++) begin
            @(negedge clock);
        end
        if (timer_irq !== level) begin
            fail_run($sformatf("timer_irq did not go to %b within %0d cycles", level, max_cycles));
        end
    endtask

    task automatic wait_ready(input logic level, input int max_cycles);
        int n;
        @(negedge clock);
        for (n = 0; n < max_cycles && sb_ready !== level; n++) begin
            @(negedge clock);
        end
        if (sb_ready !== level) begin
            fail_run($sformatf("sb_ready did not go to %b within %0d cycles", level, max_cycles));
        end
    endtask

    task automatic reset_state();
        check_data("gpio_out", sb_data_t'(gpio_out), '0);
        check_bit("timer_irq", timer_irq, 1'b0);
        check_bit("ext_write_strobe", ext_write_strobe, 1'b0);
        check_bit("ext_read_strobe", ext_read_strobe, 1'b0);
        wait_ready(1'b1, 2);
    endtask

    task automatic ram_readback();
        sb_data_t words [16];
        int       k;
        for (int i = 0; i < 16; i++) begin
            words[i] = random_word(32);
            bus_write(ram_addr(i), words[i]);
        end
        // Shuffled read order
        for (int i = 0; i < 16; i++) begin
            k = (i * 5 + 3) % 16;
            read_expect(ram_addr(k), words[k], "ram read_data");
        end
    endtask

    task automatic gpio_loopback();
        sb_data_t               value;
        logic [`GPIO_WIDTH-1:0] pins;
        value = random_word(32);
        bus_write(`GPIO_LOW + GPIO_OUT, value);
        @(posedge clock);
        @(negedge clock);
        check_data("gpio_out", sb_data_t'(gpio_out), sb_data_t'(value[`GPIO_WIDTH-1:0]));
        read_expect(`GPIO_LOW + GPIO_OUT, sb_data_t'(value[`GPIO_WIDTH-1:0]), "GPIO_OUT read");
        pins = `GPIO_WIDTH'(random_word(`GPIO_WIDTH));
        @(posedge clock);
        gpio_in <= pins;
        repeat (3) @(posedge clock);
        read_expect(`GPIO_LOW + GPIO_IN, sb_data_t'(pins), "GPIO_IN read");
    endtask

    task automatic timer_modes();
        timer_ctrl_t ctrl;
        sb_data_t    count_word;
        // One-shot with reload 5 and no prescale
        ctrl.raw = '0;
        ctrl.fields.enable = 1'b1;
        bus_write(`TIMER_LOW + TMR_RELOAD, 32'd5);
        bus_write(`TIMER_LOW + TMR_CTRL, ctrl.raw);
        wait_irq(1'b1, 12);
        ctrl.fields.enable = 1'b0;
        read_expect(`TIMER_LOW + TMR_CTRL, ctrl.raw, "timer ctrl after one-shot");
        read_expect(`TIMER_LOW + TMR_COUNT, '0, "timer count after one-shot");
        ctrl.fields.irq_clear = 1'b1;
        bus_write(`TIMER_LOW + TMR_CTRL, ctrl.raw);
        wait_irq(1'b0, 2);

        // Auto-reload with a step every second clock
        ctrl.raw = '0;
        ctrl.fields.enable      = 1'b1;
        ctrl.fields.auto_reload = 1'b1;
        ctrl.fields.prescale    = 8'd1;
        bus_write(`TIMER_LOW + TMR_RELOAD, 32'd3);
        bus_write(`TIMER_LOW + TMR_CTRL, ctrl.raw);
        wait_irq(1'b1, 16);
        read_expect(`TIMER_LOW + TMR_CTRL, ctrl.raw, "timer ctrl in auto-reload");
        // Reload keeps a running count off zero
        bus_read(`TIMER_LOW + TMR_COUNT, count_word);
        if (count_word === '0) begin
            fail_run($sformatf("timer count at zero at %0t in auto-reload mode, no reload seen",
                               $time));
        end
        ctrl.fields.irq_clear = 1'b1;
        bus_write(`TIMER_LOW + TMR_CTRL, ctrl.raw);
        wait_irq(1'b0, 2);
        wait_irq(1'b1, 16);

        // Stop the timer and drop the irq
        ctrl.raw = '0;
        ctrl.fields.irq_clear = 1'b1;
        bus_write(`TIMER_LOW + TMR_CTRL, ctrl.raw);
        wait_irq(1'b0, 2);
    endtask

    task automatic expansion_port();
        sb_addr_t addr;
        sb_data_t value;
        int       writes_before;
        addr          = `EXP_LOW + 32'h10;
        value         = random_word(32);
        writes_before = ext_write_count;
        bus_write(addr, value);
        @(posedge clock);
        @(negedge clock);
        check_data("ext_address on write", ext_last_address, addr);
        check_data("ext_write_data", ext_last_data, value);
        check_data("ext write count", sb_data_t'(ext_write_count), sb_data_t'(writes_before + 1));
        read_expect(addr, ext_answer(addr), "ext read_data");
        check_data("ext_address on read", ext_last_read, addr);
        // Back-pressure from the external slave
        @(posedge clock);
        ext_ready <= 1'b0;
        wait_ready(1'b0, 2);
        @(posedge clock);
        ext_ready <= 1'b1;
        wait_ready(1'b1, 2);
    endtask

    task automatic decode_isolation();
        sb_data_t ram_word;
        sb_data_t gpio_word;
        sb_data_t reload_word;
        int       writes_before;
        ram_word    = random_word(32);
        gpio_word   = random_word(32);
        reload_word = random_word(32);
        bus_write(`RAM_LOW, ram_word);
        bus_write(`GPIO_LOW + GPIO_OUT, gpio_word);
        bus_write(`TIMER_LOW + TMR_RELOAD, reload_word);
        writes_before = ext_write_count;
        read_expect(32'h4000_0000, '0, "unmapped read_data");
        // Low bits match each slave register and would alias under a loose decode
        bus_write(32'h4000_0000, ~ram_word);
        bus_write(32'h4000_1004, ~reload_word);
        bus_write(32'h4000_2000, ~gpio_word);
        read_expect(`RAM_LOW, ram_word, "ram after unmapped write");
        read_expect(`TIMER_LOW + TMR_RELOAD, reload_word, "reload after unmapped write");
        read_expect(`GPIO_LOW + GPIO_OUT, sb_data_t'(gpio_word[`GPIO_WIDTH-1:0]),
                    "GPIO_OUT after unmapped write");
        check_data("ext write count", sb_data_t'(ext_write_count), sb_data_t'(writes_before));
    endtask

    initial begin
        lfsr_state       = 32'd42;
        rst_n            = 1'b0;
        sb_address       = '0;
        sb_write_data    = '0;
        sb_write_strobe  = 1'b0;
        sb_read_strobe   = 1'b0;
        ext_read_data    = '0;
        ext_ready        = 1'b1;
        gpio_in          = '0;
        ext_write_count  = 0;
        ext_last_address = '0;
        ext_last_read    = '0;
        ext_last_data    = '0;
        repeat (15) @(posedge clock);
        @(negedge clock);
        check_bit("sb_ready in reset", sb_ready, 1'b0);
        check_data("sb_read_data in reset", sb_read_data, '0);
        @(posedge clock);
        rst_n <= 1'b1;
        reset_state();
        ram_readback();
        gpio_loopback();
        timer_modes();
        expansion_port();
        decode_isolation();
        $display(">>> PASS");
        $finish;
    end

    // Watchdog with twice the summed budget
    initial begin
        #(BUDGET_CYCLES * CLK_PERIOD * 2);
        fail_run("watchdog timeout, the tests did not finish in time");
    end
endmodule

// ==== logic/bus_subsystem_top.sv ====
`timescale 1ns/1ps
`include "subsys_config.svh"

module bus_subsystem_top (
    input  logic                   clock,
    input  logic                   rst_n,
    // Master side
    input  bus_pkg::sb_addr_t      sb_address,
    input  bus_pkg::sb_data_t      sb_write_data,
    input  logic                   sb_write_strobe,
    input  logic                   sb_read_strobe,
    output bus_pkg::sb_data_t      sb_read_data,
    output logic                   sb_ready,
    // Expansion slave
    output bus_pkg::sb_addr_t      ext_address,
    output bus_pkg::sb_data_t      ext_write_data,
    output logic                   ext_write_strobe,
    output logic                   ext_read_strobe,
    input  bus_pkg::sb_data_t      ext_read_data,
    input  logic                   ext_ready,
    // Peripheral pins
    input  logic [`GPIO_WIDTH-1:0] gpio_in,
    output logic [`GPIO_WIDTH-1:0] gpio_out,
    output logic                   timer_irq
);
    import bus_pkg::*;

    sb_addr_t ram_address, tmr_address, gpio_address;
    sb_data_t ram_write_data, tmr_write_data, gpio_write_data;
    sb_data_t ram_read_data, tmr_read_data, gpio_read_data;
    logic     ram_write_strobe, tmr_write_strobe, gpio_write_strobe;
    logic     ram_read_strobe, tmr_read_strobe, gpio_read_strobe;
    logic     ram_ready, tmr_ready, gpio_ready;

    simplebus_interconnect u_interconnect (
        .clock           (clock),
        .rst_n           (rst_n),
        .m_address       (sb_address),
        .m_write_data    (sb_write_data),
        .m_write_strobe  (sb_write_strobe),
        .m_read_strobe   (sb_read_strobe),
        .m_read_data     (sb_read_data),
        .m_ready         (sb_ready),
        .s1_address      (ram_address),
        .s1_write_data   (ram_write_data),
        .s1_write_strobe (ram_write_strobe),
        .s1_read_strobe  (ram_read_strobe),
        .s1_read_data    (ram_read_data),
        .s1_ready        (ram_ready),
        .s2_address      (tmr_address),
        .s2_write_data   (tmr_write_data),
        .s2_write_strobe (tmr_write_strobe),
        .s2_read_strobe  (tmr_read_strobe),
        .s2_read_data    (tmr_read_data),
        .s2_ready        (tmr_ready),
        .s3_address      (gpio_address),
        .s3_write_data   (gpio_write_data),
        .s3_write_strobe (gpio_write_strobe),
        .s3_read_strobe  (gpio_read_strobe),
        .s3_read_data    (gpio_read_data),
        .s3_ready        (gpio_ready),
        // Slave 4 leaves the subsystem as the expansion port
        .s4_address      (ext_address),
        .s4_write_data   (ext_write_data),
        .s4_write_strobe (ext_write_strobe),
        .s4_read_strobe  (ext_read_strobe),
        .s4_read_data    (ext_read_data),
        .s4_ready        (ext_ready)
    );

    scratch_ram u_ram (
        .clock        (clock),
        .rst_n        (rst_n),
        .address      (ram_address),
        .write_data   (ram_write_data),
        .write_strobe (ram_write_strobe),
        .read_strobe  (ram_read_strobe),
        .read_data    (ram_read_data),
        .ready        (ram_ready)
    );

    bus_timer u_timer (
        .clock        (clock),
        .rst_n        (rst_n),
        .address      (tmr_address),
        .write_data   (tmr_write_data),
        .write_strobe (tmr_write_strobe),
        .read_strobe  (tmr_read_strobe),
        .read_data    (tmr_read_data),
        .ready        (tmr_ready),
        .irq          (timer_irq)
    );

    gpio_port u_gpio (
        .clock        (clock),
        .rst_n        (rst_n),
        .address      (gpio_address),
        .write_data   (gpio_write_data),
        .write_strobe (gpio_write_strobe),
        .read_strobe  (gpio_read_strobe),
        .read_data    (gpio_read_data),
        .ready        (gpio_ready),
        .pins_in      (gpio_in),
        .pins_out     (gpio_out)
    );
endmodule

// ==== logic/gpio_port.sv ====
`timescale 1ns/1ps
`include "subsys_config.svh"

module gpio_port (
    input  logic                   clock,
    input  logic                   rst_n,
    input  bus_pkg::sb_addr_t      address,
    input  bus_pkg::sb_data_t      write_data,
    input  logic                   write_strobe,
    input  logic                   read_strobe,
    output bus_pkg::sb_data_t      read_data,
    output logic                   ready,
    input  logic [`GPIO_WIDTH-1:0] pins_in,
    output logic [`GPIO_WIDTH-1:0] pins_out
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [`GPIO_WIDTH-1:0] out_reg;
    logic [`GPIO_WIDTH-1:0] sync_meta;
    logic [`GPIO_WIDTH-1:0] sync_q;
    reg_offset_t            offset;

    assign offset   = address[7:0];
    assign pins_out = out_reg;

    // Two-flop synchronizer on the input pins
    always_ff @(posedge clock) begin
        sync_meta <= pins_in;
        sync_q    <= sync_meta;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_reg   <= '0;
            read_data <= '0;
            ready     <= 1'b0;
        end else begin
            ready     <= 1'b1;
            read_data <= '0;
            if (write_strobe && offset == GPIO_OUT) begin
                out_reg <= write_data[`GPIO_WIDTH-1:0];
            end
            if (read_strobe) begin
                case (offset)
                    GPIO_OUT: read_data <= sb_data_t'(out_reg);
                    GPIO_IN:  read_data <= sb_data_t'(sync_q);
                    default:  read_data <= '0;
                endcase
            end
        end
    end
endmodule

// ==== logic/bus_timer.sv ====
`timescale 1ns/1ps

module bus_timer (
    input  logic              clock,
    input  logic              rst_n,
    input  bus_pkg::sb_addr_t address,
    input  bus_pkg::sb_data_t write_data,
    input  logic              write_strobe,
    input  logic              read_strobe,
    output bus_pkg::sb_data_t read_data,
    output logic              ready,
    output logic              irq
);
    import bus_pkg::*;
    import periph_pkg::*;

    timer_ctrl_t ctrl;
    timer_ctrl_t wr_ctrl;
    sb_data_t    reload;
    sb_data_t    count;
    logic [7:0]  prescale_cnt;
    reg_offset_t offset;

    assign offset      = address[7:0];
    assign wr_ctrl.raw = write_data;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl.raw     <= '0;
            reload       <= '0;
            count        <= '0;
            prescale_cnt <= '0;
            irq          <= 1'b0;
            read_data    <= '0;
            ready        <= 1'b0;
        end else begin
            ready     <= 1'b1;
            read_data <= '0;

            // Count down one step every prescale+1 clocks
            if (ctrl.fields.enable) begin
                if (prescale_cnt == ctrl.fields.prescale) begin
                    prescale_cnt <= '0;
                    if (count == 32'd1) begin
                        irq <= 1'b1;
                        if (ctrl.fields.auto_reload) begin
                            count <= reload;
                        end else begin
                            count               <= '0;
                            ctrl.fields.enable  <= 1'b0;
                        end
                    end else if (count != '0) begin
                        count <= count - 32'd1;
                    end
                end else begin
                    prescale_cnt <= prescale_cnt + 8'd1;
                end
            end

            // Bus writes take priority over the counter
            if (write_strobe) begin
                case (offset)
                    TMR_CTRL: begin
                        ctrl.raw              <= wr_ctrl.raw;
                        ctrl.fields.irq_clear <= 1'b0;
                        if (wr_ctrl.fields.irq_clear) begin
                            irq <= 1'b0;
                        end
                        // Enabling restarts from the reload value
                        if (wr_ctrl.fields.enable) begin
                            count        <= reload;
                            prescale_cnt <= '0;
                        end
                    end
                    TMR_RELOAD: reload <= write_data;
                    default: ;
                endcase
            end

            if (read_strobe) begin
                case (offset)
                    TMR_CTRL:   read_data <= ctrl.raw;
                    TMR_RELOAD: read_data <= reload;
                    TMR_COUNT:  read_data <= count;
                    default:    read_data <= '0;
                endcase
            end
        end
    end
endmodule

// ==== logic/scratch_ram.sv ====
`timescale 1ns/1ps
`include "subsys_config.svh"

module scratch_ram (
    input  logic              clock,
    input  logic              rst_n,
    input  bus_pkg::sb_addr_t address,
    input  bus_pkg::sb_data_t write_data,
    input  logic              write_strobe,
    input  logic              read_strobe,
    output bus_pkg::sb_data_t read_data,
    output logic              ready
);
    import bus_pkg::*;

    localparam int INDEX_BITS = $clog2(`RAM_WORDS);

    sb_data_t              mem [`RAM_WORDS];
    logic [INDEX_BITS-1:0] index;

    // Word index, the byte offset bits are dropped
    assign index = address[INDEX_BITS+1:2];

    always_ff @(posedge clock) begin
        if (write_strobe) begin
            mem[index] <= write_data;
        end
    end

    // One-cycle answer, zero the rest of the time
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data <= '0;
            ready     <= 1'b0;
        end else begin
            ready     <= 1'b1;
            read_data <= read_strobe ? mem[index] : '0;
        end
    end
endmodule

// ==== logic/simplebus_interconnect.sv ====
`timescale 1ns/1ps
`include "subsys_config.svh"

module simplebus_interconnect (
    input  logic              clock,
    input  logic              rst_n,
    // Master side
    input  bus_pkg::sb_addr_t m_address,
    input  bus_pkg::sb_data_t m_write_data,
    input  logic              m_write_strobe,
    input  logic              m_read_strobe,
    output bus_pkg::sb_data_t m_read_data,
    output logic              m_ready,
    // Slave 1
    output bus_pkg::sb_addr_t s1_address,
    output bus_pkg::sb_data_t s1_write_data,
    output logic              s1_write_strobe,
    output logic              s1_read_strobe,
    input  bus_pkg::sb_data_t s1_read_data,
    input  logic              s1_ready,
    // Slave 2
    output bus_pkg::sb_addr_t s2_address,
    output bus_pkg::sb_data_t s2_write_data,
    output logic              s2_write_strobe,
    output logic              s2_read_strobe,
    input  bus_pkg::sb_data_t s2_read_data,
    input  logic              s2_ready,
    // Slave 3
    output bus_pkg::sb_addr_t s3_address,
    output bus_pkg::sb_data_t s3_write_data,
    output logic              s3_write_strobe,
    output logic              s3_read_strobe,
    input  bus_pkg::sb_data_t s3_read_data,
    input  logic              s3_ready,
    // Slave 4
    output bus_pkg::sb_addr_t s4_address,
    output bus_pkg::sb_data_t s4_write_data,
    output logic              s4_write_strobe,
    output logic              s4_read_strobe,
    input  bus_pkg::sb_data_t s4_read_data,
    input  logic              s4_ready
);
    import bus_pkg::*;

    logic [3:0] hit;

    function automatic logic in_window(sb_addr_t addr, sb_addr_t low, sb_addr_t high);
        return (addr >= low) && (addr < high);
    endfunction

    // Window decode, at most one bit set since the windows don't overlap
    assign hit[0] = in_window(m_address, `RAM_LOW, `RAM_HIGH);
    assign hit[1] = in_window(m_address, `TIMER_LOW, `TIMER_HIGH);
    assign hit[2] = in_window(m_address, `GPIO_LOW, `GPIO_HIGH);
    assign hit[3] = in_window(m_address, `EXP_LOW, `EXP_HIGH);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            {s1_address, s1_write_data, s1_write_strobe, s1_read_strobe} <= '0;
            {s2_address, s2_write_data, s2_write_strobe, s2_read_strobe} <= '0;
            {s3_address, s3_write_data, s3_write_strobe, s3_read_strobe} <= '0;
            {s4_address, s4_write_data, s4_write_strobe, s4_read_strobe} <= '0;
            m_read_data <= '0;
            m_ready     <= 1'b0;
        end else begin
            // Unselected slaves see an all-zero request
            s1_address      <= hit[0] ? m_address : '0;
            s1_write_data   <= hit[0] ? m_write_data : '0;
            s1_write_strobe <= hit[0] & m_write_strobe;
            s1_read_strobe  <= hit[0] & m_read_strobe;

            s2_address      <= hit[1] ? m_address : '0;
            s2_write_data   <= hit[1] ? m_write_data : '0;
            s2_write_strobe <= hit[1] & m_write_strobe;
            s2_read_strobe  <= hit[1] & m_read_strobe;

            s3_address      <= hit[2] ? m_address : '0;
            s3_write_data   <= hit[2] ? m_write_data : '0;
            s3_write_strobe <= hit[2] & m_write_strobe;
            s3_read_strobe  <= hit[2] & m_read_strobe;

            s4_address      <= hit[3] ? m_address : '0;
            s4_write_data   <= hit[3] ? m_write_data : '0;
            s4_write_strobe <= hit[3] & m_write_strobe;
            s4_read_strobe  <= hit[3] & m_read_strobe;

            // Idle slaves drive zero, so OR picks out the one answering
            m_read_data <= s1_read_data | s2_read_data | s3_read_data | s4_read_data;
            m_ready     <= s1_ready & s2_ready & s3_ready & s4_ready;
        end
    end
endmodule

// ==== common/periph_pkg.sv ====
// Register layout of the internal peripherals
package periph_pkg;

    // Offset of a register inside its slave window
    typedef logic [7:0] reg_offset_t;

    // Timer control fields, bit 0 at the bottom
    typedef struct packed {
        logic [15:0] reserved_hi;
        logic [7:0]  prescale;
        logic [4:0]  reserved_lo;
        logic        irq_clear;   // Write-only pulse, reads back as 0
        logic        auto_reload;
        logic        enable;
    } timer_fields_t;

    // Control word, stored raw and decoded through the fields
    typedef union packed {
        logic [31:0]   raw;
        timer_fields_t fields;
    } timer_ctrl_t;

    // Timer registers
    localparam reg_offset_t TMR_CTRL   = 8'h00;
    localparam reg_offset_t TMR_RELOAD = 8'h04;
    localparam reg_offset_t TMR_COUNT  = 8'h08;

    // GPIO registers
    localparam reg_offset_t GPIO_OUT = 8'h00;
    localparam reg_offset_t GPIO_IN  = 8'h04;

endpackage

// ==== common/bus_pkg.sv ====
// Word types for the simple bus
//
// Every bus port in the subsystem carries a byte address and a data word.
// Both are 32 bits wide.
// The address is a byte address, so word-addressed slaves drop bits 1:0.
package bus_pkg;

    // Byte address presented by the master
    typedef logic [31:0] sb_addr_t;

    // Data word for both directions
    typedef logic [31:0] sb_data_t;

endpackage

// ==== common/subsys_config.svh ====
`ifndef SUBSYS_CONFIG_SVH
`define SUBSYS_CONFIG_SVH

// Address map, each window runs from LOW up to but not including HIGH
`define RAM_LOW   32'h0000_0000
`define RAM_HIGH  32'h0000_1000

`define TIMER_LOW  32'h0000_1000
`define TIMER_HIGH 32'h0000_1100

`define GPIO_LOW  32'h0000_2000
`define GPIO_HIGH 32'h0000_2100

// Expansion port takes the upper half of the space
`define EXP_LOW  32'h8000_0000
`define EXP_HIGH 32'hFFFF_FFFF

// Scratch RAM depth in 32-bit words
`define RAM_WORDS 1024

// Width of the GPIO pin buses
`define GPIO_WIDTH 16

`endif
